//--- key_codes.svh
`ifndef KEY_CODES_SVH
`define KEY_CODES_SVH

// one-hot arrow key codes, zero means no key
`define UP    4'b1000
`define DOWN  4'b0100
`define LEFT  4'b0010
`define RIGHT 4'b0001

`endif

//--- chart_pkg.sv
package chart_pkg;

    localparam int name_len   = 12;
    localparam int num_charts = 4;

    // first character sits in the MSB, matching the screen rows
    typedef logic [0:8*name_len-1] chart_name_t;

    typedef struct packed {
        chart_name_t name;
        logic [15:0] best;
    } chart_info_t;

    localparam chart_name_t blank_name = {name_len{" "}};

    // indexed by chart id, id 0 means no chart
    localparam chart_name_t chart_names [1:num_charts] = '{
        "Neon Drift  ",
        "Paper Moon  ",
        "Clockwork   ",
        "Starfall    "
    };

    localparam logic [15:0] chart_best [1:num_charts] = '{
        16'h3a7c,
        16'h1f02,
        16'h8e41,
        16'h0c95
    };

endpackage

//--- screen_pkg.sv
package screen_pkg;

    localparam int text_rows = 11;
    localparam int text_cols = 32;
    localparam int seg_chars = 8;

    // character 0 of a row is the leftmost one, in the MSB
    typedef logic [0:8*text_cols-1] text_row_t;
    typedef text_row_t [0:text_rows-1] screen_text_t;

    typedef logic [0:8*seg_chars-1] seg_text_t;

    typedef enum logic [1:0] {
        MENU,
        HISTORY,
        PLAY
    } top_state_t;

endpackage

//--- chart_store.sv
`timescale 1ns/1ps

module chart_store (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  byte                    menu_id,
    output chart_pkg::chart_info_t menu_info,
    input  byte                    hist_id,
    output chart_pkg::chart_info_t hist_info
);

    function automatic chart_pkg::chart_info_t lookup(input byte id);
        chart_pkg::chart_info_t info;
        info.name = chart_pkg::blank_name;
        info.best = 16'h0000;
        if (id >= 1 && id <= chart_pkg::num_charts) begin
            info.name = chart_pkg::chart_names[id];
            info.best = chart_pkg::chart_best[id];
        end
        return info;
    endfunction

    // menu port
    always_ff @(posedge prog_clk) begin
        if (rst) begin
            menu_info <= '0;
        end else begin
            menu_info <= lookup(menu_id);
        end
    end

    // history port
    always_ff @(posedge prog_clk) begin
        if (rst) begin
            hist_info <= '0;
        end else begin
            hist_info <= lookup(hist_id);
        end
    end

endmodule

//--- page_menu.sv
`timescale 1ns/1ps
`include "key_codes.svh"

module page_menu #(
    parameter int num_entries = 6
) (
    input  logic                     prog_clk,
    input  logic                     rst,
    input  logic                     active,
    input  logic [3:0]               arrow_keys,
    output byte                      read_id,
    input  chart_pkg::chart_info_t   chart_info,
    output screen_pkg::screen_text_t text,
    output screen_pkg::seg_text_t    seg,
    output logic                     req,
    output screen_pkg::top_state_t   req_state,
    output logic                     req_auto
);

    typedef logic [$clog2(num_entries)-1:0] cursor_t;

    cursor_t    cursor;
    cursor_t    cursor_next;
    logic [2:0] load_id;   // next id to fetch, 0 once loading is done
    logic [2:0] info_id;   // id that chart_info belongs to
    logic       keys_on;

    function automatic screen_pkg::seg_text_t seg_for(input cursor_t c);
        if (c == 0)
            return "history ";
        else if (c == 1)
            return "free    ";
        else
            return {"song  0", 8'(8'h2f + 8'(c))};   // entry 2 shows chart 1
    endfunction

    assign keys_on = active && (load_id == 3'd0);

    always_comb begin
        cursor_next = cursor;
        if (keys_on) begin
            case (arrow_keys)
                `UP:     cursor_next = (cursor == 0) ? cursor_t'(num_entries - 1) : cursor - 1'b1;
                `DOWN:   cursor_next = (cursor == cursor_t'(num_entries - 1)) ? '0 : cursor + 1'b1;
                default: cursor_next = cursor;
            endcase
        end
    end

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            cursor    <= '0;
            load_id   <= 3'd1;
            info_id   <= 3'd0;
            read_id   <= 8'sd0;
            req       <= 1'b0;
            req_state <= screen_pkg::MENU;
            req_auto  <= 1'b0;
            seg       <= {screen_pkg::seg_chars{" "}};
            text[0]   <= {{10{"="}}, "  Main Menu  ", {9{"="}}};
            text[1]   <= {">>> Score History", {15{" "}}};
            text[2]   <= {{11{"-"}}, "  Charts  ", {11{"-"}}};
            text[3]   <= {"    [0]  Free Play", {14{" "}}};
            for (int i = 1; i <= chart_pkg::num_charts; i++)
                text[3 + i] <= {"    [", 8'(8'h30 + i), "]", {25{" "}}};
            text[8]   <= {screen_pkg::text_cols{" "}};
            text[9]   <= {"[^][v] Move Up / Down", {11{" "}}};
            text[10]  <= {"[<] Auto", {10{" "}}, "[>] Play Chart"};
        end else begin
            cursor  <= cursor_next;
            info_id <= read_id[2:0];
            req     <= 1'b0;

            // free play on row 3, charts below it
            for (int i = 0; i < num_entries; i++)
                text[(i == 0) ? 1 : i + 2][0 +: 24] <= (cursor_t'(i) == cursor_next) ? ">>>" : "   ";

            if (info_id >= 1 && info_id <= chart_pkg::num_charts)
                text[3 + info_id][9*8 +: 8*chart_pkg::name_len] <= chart_info.name;

            if (load_id != 3'd0) begin
                read_id <= byte'(load_id);
                load_id <= (load_id == 3'd5) ? 3'd0 : load_id + 3'd1;
            end else begin
                read_id <= 8'sd0;
                seg     <= seg_for(cursor_next);
                if (active) begin
                    case (arrow_keys)
                        `RIGHT: begin
                            req       <= 1'b1;
                            req_state <= (cursor == 0) ? screen_pkg::HISTORY : screen_pkg::PLAY;
                            req_auto  <= 1'b0;
                        end
                        `LEFT: begin
                            if (cursor != 0) begin
                                req       <= 1'b1;
                                req_state <= screen_pkg::PLAY;
                                req_auto  <= 1'b1;   // watch the chart play itself
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

//--- page_history.sv
`timescale 1ns/1ps
`include "key_codes.svh"

module page_history (
    input  logic                     prog_clk,
    input  logic                     rst,
    input  logic                     active,
    input  logic [3:0]               arrow_keys,
    output byte                      read_id,
    input  chart_pkg::chart_info_t   chart_info,
    output screen_pkg::screen_text_t text,
    output screen_pkg::seg_text_t    seg,
    output logic                     req,
    output screen_pkg::top_state_t   req_state
);

    logic       active_q;
    logic [2:0] load_id;   // 0 when idle
    logic [2:0] info_id;

    // best score as four lower case hex digits
    function automatic logic [0:31] hex4(input logic [15:0] v);
        logic [0:31] s;
        logic [3:0]  n;
        for (int i = 0; i < 4; i++) begin
            n = v[15 - 4*i -: 4];
            s[8*i +: 8] = (n < 4'd10) ? 8'h30 + 8'(n) : 8'h57 + 8'(n);
        end
        return s;
    endfunction

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            active_q  <= 1'b0;
            load_id   <= 3'd0;
            info_id   <= 3'd0;
            read_id   <= 8'sd0;
            req       <= 1'b0;
            req_state <= screen_pkg::MENU;
            seg       <= {screen_pkg::seg_chars{" "}};
            text[0]   <= {{9{"="}}, "  Score History  ", {6{"="}}};
            text[1]   <= {"      Chart", {9{" "}}, "Best", {8{" "}}};
            for (int i = 1; i <= chart_pkg::num_charts; i++)
                text[1 + i] <= {"  [", 8'(8'h30 + i), "] ", {26{" "}}};
            for (int r = 6; r < screen_pkg::text_rows - 1; r++)
                text[r] <= {screen_pkg::text_cols{" "}};
            text[10]  <= {"[<] Back to Menu", {16{" "}}};
        end else begin
            active_q <= active;
            info_id  <= read_id[2:0];
            req      <= 1'b0;

            if (info_id >= 1 && info_id <= chart_pkg::num_charts) begin
                text[1 + info_id][6*8 +: 8*chart_pkg::name_len] <= chart_info.name;
                text[1 + info_id][20*8 +: 32] <= hex4(chart_info.best);
            end

            if (active && !active_q) begin   // page just opened, reload all rows
                read_id <= 8'sd1;
                load_id <= 3'd2;
                seg     <= "scores  ";
            end else if (load_id != 3'd0) begin
                read_id <= byte'(load_id);
                load_id <= (load_id == 3'd5) ? 3'd0 : load_id + 3'd1;
            end else begin
                read_id <= 8'sd0;
                if (active && arrow_keys == `LEFT) begin
                    req       <= 1'b1;
                    req_state <= screen_pkg::MENU;
                end
            end
        end
    end

endmodule

//--- page_arbiter.sv
`timescale 1ns/1ps

module page_arbiter (
    input  logic                     prog_clk,
    input  logic                     rst,
    input  logic                     menu_req,
    input  screen_pkg::top_state_t   menu_state,
    input  logic                     menu_auto,
    input  logic                     hist_req,
    input  screen_pkg::top_state_t   hist_state,
    input  logic                     play_done,
    input  screen_pkg::screen_text_t menu_text,
    input  screen_pkg::screen_text_t hist_text,
    input  screen_pkg::seg_text_t    menu_seg,
    input  screen_pkg::seg_text_t    hist_seg,
    output logic                     menu_active,
    output logic                     history_active,
    output screen_pkg::top_state_t   state,
    output logic                     auto_play,
    output screen_pkg::screen_text_t text,
    output screen_pkg::seg_text_t    seg
);

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            state     <= screen_pkg::MENU;
            auto_play <= 1'b0;
        end else begin
            case (state)
                screen_pkg::MENU: begin
                    if (menu_req) begin
                        state     <= menu_state;
                        auto_play <= menu_auto;
                    end
                end
                screen_pkg::HISTORY: if (hist_req) state <= hist_state;
                screen_pkg::PLAY:    if (play_done) state <= screen_pkg::MENU;   // play page is external
                default:             state <= screen_pkg::MENU;
            endcase
        end
    end

    assign menu_active    = (state == screen_pkg::MENU);
    assign history_active = (state == screen_pkg::HISTORY);

    // menu screen stays up behind the play page
    assign text = history_active ? hist_text : menu_text;
    assign seg  = history_active ? hist_seg : menu_seg;

endmodule

//--- rhythm_menu_top.sv
`timescale 1ns/1ps

module rhythm_menu_top #(
    parameter int num_entries = 6
) (
    input  logic                     prog_clk,
    input  logic                     rst,
    input  logic [3:0]               arrow_keys,
    input  logic                     play_done,
    output screen_pkg::screen_text_t text,
    output screen_pkg::seg_text_t    seg,
    output screen_pkg::top_state_t   state,
    output logic                     auto_play
);

    byte                      menu_id;
    byte                      hist_id;
    chart_pkg::chart_info_t   menu_info;
    chart_pkg::chart_info_t   hist_info;
    screen_pkg::screen_text_t menu_text;
    screen_pkg::screen_text_t hist_text;
    screen_pkg::seg_text_t    menu_seg;
    screen_pkg::seg_text_t    hist_seg;
    logic                     menu_active;
    logic                     history_active;
    logic                     menu_req;
    logic                     menu_auto;
    logic                     hist_req;
    screen_pkg::top_state_t   menu_state;
    screen_pkg::top_state_t   hist_state;

    chart_store store0 (
        .prog_clk (prog_clk), .rst (rst),
        .menu_id (menu_id), .menu_info (menu_info),
        .hist_id (hist_id), .hist_info (hist_info)
    );

    page_menu #(.num_entries(num_entries)) menu0 (
        .prog_clk (prog_clk), .rst (rst), .active (menu_active), .arrow_keys (arrow_keys),
        .read_id (menu_id), .chart_info (menu_info), .text (menu_text), .seg (menu_seg),
        .req (menu_req), .req_state (menu_state), .req_auto (menu_auto)
    );

    page_history hist0 (
        .prog_clk (prog_clk), .rst (rst), .active (history_active), .arrow_keys (arrow_keys),
        .read_id (hist_id), .chart_info (hist_info), .text (hist_text), .seg (hist_seg),
        .req (hist_req), .req_state (hist_state)
    );

    page_arbiter arb0 (
        .prog_clk (prog_clk), .rst (rst),
        .menu_req (menu_req), .menu_state (menu_state), .menu_auto (menu_auto),
        .hist_req (hist_req), .hist_state (hist_state), .play_done (play_done),
        .menu_text (menu_text), .hist_text (hist_text),
        .menu_seg (menu_seg), .hist_seg (hist_seg),
        .menu_active (menu_active), .history_active (history_active),
        .state (state), .auto_play (auto_play), .text (text), .seg (seg)
    );

endmodule

//--- tb_rhythm_menu.sv
`timescale 1ns/1ps
`include "key_codes.svh"

module tb_rhythm_menu;

    localparam int num_entries  = 6;
    localparam int reset_cycles = 3;
    localparam int num_moves    = 40;
    localparam int num_plays    = 8;
    localparam int num_visits   = 2;
    localparam int wait_limit   = 8;
    localparam int press_cycles = 4 + wait_limit;   // drive, random idle, state wait
    localparam int max_cycles   = 2 * (reset_cycles + 8 + num_moves * press_cycles
                                       + num_visits * 6 * press_cycles
                                       + (num_plays + 1) * 10 * press_cycles);

    logic                     prog_clk;
    logic                     rst;
    logic [3:0]               arrow_keys;
    logic                     play_done;
    screen_pkg::screen_text_t text;
    screen_pkg::seg_text_t    seg;
    screen_pkg::top_state_t   state;
    logic                     auto_play;

    // reference model
    int                       m_cursor;
    screen_pkg::top_state_t   m_state;
    logic                     m_auto;

    integer seed = 72;
    int     errors;
    int     checks;
    int     cycles;
    int     test_num;
    int     tests_failed;
    int     errors_at_start;

    rhythm_menu_top #(.num_entries(num_entries)) dut0 (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .arrow_keys (arrow_keys),
        .play_done  (play_done),
        .text       (text),
        .seg        (seg),
        .state      (state),
        .auto_play  (auto_play)
    );

    initial begin
        prog_clk = 1'b0;
        forever #2 prog_clk = ~prog_clk;
    end

    always @(posedge prog_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compare(input logic [255:0] got, input logic [255:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic screen_pkg::seg_text_t menu_seg_text(input int c);
        if (c == 0)
            return "history ";
        if (c == 1)
            return "free    ";
        return {"song  0", 8'(8'h30 + c - 1)};   // entry 2 is chart 1
    endfunction

    function automatic logic [0:31] hex_text(input logic [15:0] v);
        string       s;
        logic [0:31] r;
        s = $sformatf("%h", v);
        for (int i = 0; i < 4; i++)
            r[8*i +: 8] = s[i];
        return r;
    endfunction

    task automatic model_key(input logic [3:0] key);
        if (m_state == screen_pkg::MENU) begin
            case (key)
                `UP:    m_cursor = (m_cursor + num_entries - 1) % num_entries;
                `DOWN:  m_cursor = (m_cursor + 1) % num_entries;
                `RIGHT: begin
                    m_state = (m_cursor == 0) ? screen_pkg::HISTORY : screen_pkg::PLAY;
                    m_auto  = 1'b0;
                end
                `LEFT: begin
                    if (m_cursor != 0) begin
                        m_state = screen_pkg::PLAY;
                        m_auto  = 1'b1;
                    end
                end
                default: ;
            endcase
        end else if (m_state == screen_pkg::HISTORY && key == `LEFT) begin
            m_state = screen_pkg::MENU;
        end
    endtask

    task automatic wait_state(input screen_pkg::top_state_t exp);
        int n;
        n = 0;
        while (state != exp && n < wait_limit) begin
            @(negedge prog_clk);
            n++;
        end
        if (state != exp) begin
            errors++;
            $display("error at %0t ns: state never became %s within %0d cycles",
                     $time, exp.name(), wait_limit);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge prog_clk);
        @(negedge prog_clk);
    endtask

    task automatic check_menu();
        int r;
        compare(state, m_state, "state");
        compare(auto_play, m_auto, "auto_play");
        compare(seg, menu_seg_text(m_cursor), "segment text");
        for (int e = 0; e < num_entries; e++) begin
            r = (e == 0) ? 1 : e + 2;   // free play and charts sit below the divider
            compare(text[r][0 +: 24], (e == m_cursor) ? ">>>" : "   ",
                    $sformatf("marker on row %0d", r));
        end
    endtask

    task automatic check_history();
        compare(state, screen_pkg::HISTORY, "state");
        compare(seg, "scores  ", "segment text");
        for (int id = 1; id <= chart_pkg::num_charts; id++) begin
            compare(text[1 + id][48 +: 96], chart_pkg::chart_names[id],
                    $sformatf("history name %0d", id));
            compare(text[1 + id][160 +: 32], hex_text(chart_pkg::chart_best[id]),
                    $sformatf("history score %0d", id));
        end
    endtask

    // one key for one cycle, then check where the key has landed
    task automatic press_key(input logic [3:0] key);
        @(posedge prog_clk);
        arrow_keys <= key;
        @(posedge prog_clk);
        arrow_keys <= 4'b0000;
        @(negedge prog_clk);
        model_key(key);
        wait_state(m_state);
        if (m_state != screen_pkg::HISTORY)
            check_menu();
    endtask

    task automatic move_to(input int target);
        int d;
        while (m_cursor != target) begin
            d = (target - m_cursor + num_entries) % num_entries;
            press_key((d <= num_entries / 2) ? `DOWN : `UP);
        end
    endtask

    task automatic end_play();
        @(posedge prog_clk);
        play_done <= 1'b1;
        @(posedge prog_clk);
        play_done <= 1'b0;
        @(negedge prog_clk);
        m_state = screen_pkg::MENU;
        wait_state(screen_pkg::MENU);
        check_menu();
    endtask

    task automatic start_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
        end
    endtask

    initial begin
        logic [3:0] key;
        rst          = 1'b1;
        arrow_keys   = 4'b0000;
        play_done    = 1'b0;
        m_cursor     = 0;
        m_state      = screen_pkg::MENU;
        m_auto       = 1'b0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        test_num     = 0;
        tests_failed = 0;

        repeat (reset_cycles) @(posedge prog_clk);
        rst <= 1'b0;

        start_test();
        idle(6);
        for (int id = 1; id <= chart_pkg::num_charts; id++)
            compare(text[3 + id][72 +: 96], chart_pkg::chart_names[id],
                    $sformatf("menu name %0d", id));
        check_menu();
        finish_test("reset and chart load");

        start_test();
        for (int i = 0; i < num_moves; i++) begin
            key = ({$random(seed)} % 2) ? `UP : `DOWN;
            press_key(key);
            repeat ({$random(seed)} % 3) @(posedge prog_clk);
        end
        finish_test("cursor moves");

        start_test();
        repeat (num_visits) begin
            move_to(0);
            press_key(`RIGHT);
            idle(6);   // rows reload on every entry
            check_history();
            press_key(`LEFT);
        end
        finish_test("score history");

        start_test();
        repeat (num_plays) begin
            move_to(1 + {$random(seed)} % (num_entries - 1));
            press_key(({$random(seed)} % 2) ? `LEFT : `RIGHT);
            repeat (3) press_key(4'b0001 << ({$random(seed)} % 4));
            idle(2);
            check_menu();
            end_play();
        end
        finish_test("play requests");

        start_test();
        move_to(0);
        press_key(`LEFT);
        idle(2);
        check_menu();
        move_to(1);
        press_key(`RIGHT);
        press_key(`UP);
        press_key(`DOWN);
        press_key(`LEFT);
        press_key(`RIGHT);
        idle(2);
        check_menu();
        end_play();
        finish_test("ignored keys");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
chart_pkg.sv
screen_pkg.sv
chart_store.sv
page_menu.sv
page_history.sv
page_arbiter.sv
rhythm_menu_top.sv
tb_rhythm_menu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rhythm_menu
RTL_TOP   ?= rhythm_menu_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
